// File: project.f
+incdir+hdl
hdl/sdCardPkg.sv
hdl/cmdReceiver.sv
hdl/cardStatus.sv
hdl/cardEngine.sv
hdl/misoSerializer.sv
hdl/blockMemory.sv
hdl/sdSpiCard.sv
test/tbChecker.sv
test/tbTop.sv

// File: run_sim.sh
#!/bin/sh
# builds the SD card testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbTop -f project.f -o simTb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if grep -qx "TB PASSED" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: test/tbTop.sv
// ------------------------------------------------
// SD card testbench top
// host side of the SPI bus, shadow of the card
// memory and the reference for every reply
// ------------------------------------------------
`default_nettype none
`include "sdCard_defs.svh"

module tbTop
   import sdCardPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int REPLY_TIMEOUT = 10000;              // sclk cycles per wait
   localparam logic [15:0] DUMMY_CRC = `SD_DUMMY_CRC;

   logic       sclk;
   logic       rstn;
   logic       ncs;
   logic       mosi;
   logic       miso;
   int         errCount;
   int         timeouts = 0;
   int         seed = 34161;
   logic       modelInit = 1'b0;   // card model state
   logic       modelApp = 1'b0;
   logic [7:0] shadow [`SD_MEM_BYTES];
   logic [7:0] pattern;

   sdSpiCard dut0 (.sclk, .rstn, .ncs, .mosi, .miso);
   tbChecker chk0 (.sclk, .rstn, .miso, .errCount);

   always #10 sclk = ~sclk;

   // expected {tail present, R1, tail} for a command in the present model state
   function automatic logic [40:0] refReply(input logic [5:0] idx, input logic [31:0] arg);
      logic [7:0] base;
      logic [3:0] vhs;
      base = modelInit ? 8'h00 : 8'h01;
      vhs = (arg[11:8] == `SD_CARD_VHS) ? arg[11:8] : 4'h0;
      case (idx)
         CMD_GO_IDLE:       return {1'b0, 8'h01, 32'd0};
         CMD_SEND_IF_COND:  return {1'b1, base, 20'd0, vhs, arg[7:0]};
         CMD_APP_CMD:       return {1'b0, base, 32'd0};
         CMD_READ_OCR:      return {1'b1, base, `SD_OCR_BASE | {modelInit, 31'd0}};
         ACMD_SEND_OP_COND: return {1'b0, modelApp ? 8'h00 : (base | 8'h04), 32'd0};
         CMD_READ_BLOCK, CMD_WRITE_BLOCK: begin
            if (!modelInit)
               return {1'b0, base | 8'h04, 32'd0};
            if (arg[8:0] != 9'd0 || arg >= 32'(`SD_MEM_BYTES))
               return {1'b0, base | 8'h20, 32'd0};
            return {1'b0, base, 32'd0};
         end
         default:           return {1'b0, base | 8'h04, 32'd0};
      endcase
   endfunction

   task automatic sendByte(input logic [7:0] b);
      logic [7:0] sr;
      sr = b;
      repeat (8) begin
         @(negedge sclk);
         mosi = sr[7];          // MSB first
         sr = {sr[6:0], 1'b1};
      end
   endtask

   task automatic sendIdle(input int n);
      repeat (n) sendByte(8'hFF);
   endtask

   task automatic waitReplies(input string what);
      int n;
      n = 0;
      while (chk0.pendingBytes() != 0 && n < REPLY_TIMEOUT) begin
         @(negedge sclk);
         n++;
      end
      if (chk0.pendingBytes() != 0) begin
         $display("timeout at %0t: the card never finished its reply to %s", $time, what);
         timeouts++;
         chk0.dropExpected();
      end
   endtask

   task automatic waitMisoHigh();
      int n;
      n = 0;
      @(posedge sclk);
      while (miso !== 1'b1 && n < REPLY_TIMEOUT) begin
         @(posedge sclk);
         n++;
      end
      if (miso !== 1'b1) begin
         $display("timeout at %0t: miso stayed low after the write busy period", $time);
         timeouts++;
      end
   endtask

   task automatic beginTxn();
      @(negedge sclk);
      ncs = 1'b0;
      sendIdle(1);
   endtask

   task automatic finishTxn();
      sendIdle(4);   // any stray token or data would show here
      @(negedge sclk);
      ncs = 1'b1;
      sendIdle(2);
   endtask

   // queue the reply the card owes, then send the frame and wait for it
   task automatic runCommand(input logic [5:0] idx, input logic [31:0] arg);
      logic [40:0] reply;
      logic [47:0] frame;
      logic [31:0] tail;
      reply = refReply(idx, arg);
      frame = {2'b01, idx, arg, 7'h4A, 1'b1};   // CRC7 not checked by the card
      tail = reply[31:0];
      chk0.expectFirst(reply[39:32]);
      if (reply[40]) begin
         repeat (4) begin
            chk0.expectNext(tail[31:24]);
            tail = tail << 8;
         end
      end
      if (idx == CMD_READ_BLOCK && reply[39:32] == 8'h00) begin
         chk0.expectToken(`SD_TOKEN_START);
         for (int k = 0; k < `SD_BLOCK_LEN; k++)
            chk0.expectNext(shadow[arg[11:0] + 12'(k)]);
         chk0.expectNext(DUMMY_CRC[15:8]);
         chk0.expectNext(DUMMY_CRC[7:0]);
      end
      if (idx == CMD_GO_IDLE)
         modelInit = 1'b0;
      if (idx == ACMD_SEND_OP_COND && modelApp)
         modelInit = 1'b1;
      modelApp = (idx == CMD_APP_CMD);
      repeat (6) begin
         sendByte(frame[47:40]);
         frame = frame << 8;
      end
      waitReplies("a command");
   endtask

   task automatic transact(input logic [5:0] idx, input logic [31:0] arg);
      beginTxn();
      runCommand(idx, arg);
      finishTxn();
   endtask

   task automatic writeBlock(input logic [11:0] addr);
      logic [7:0] b;
      beginTxn();
      runCommand(CMD_WRITE_BLOCK, {20'd0, addr});
      chk0.expectFirst(`SD_DATA_ACCEPTED);
      repeat (`SD_BUSY_BYTES) chk0.expectNext(8'h00);   // busy holds miso low
      sendByte(8'hFF);
      sendByte(`SD_TOKEN_START);
      for (int k = 0; k < `SD_BLOCK_LEN; k++) begin
         b = 8'($random(seed));
         sendByte(b);
         shadow[addr + 12'(k)] = b;
      end
      sendByte(8'h3C);   // CRC16 is ignored by the card
      sendByte(8'hC3);
      @(negedge sclk);
      mosi = 1'b1;
      waitReplies("the write data");
      waitMisoHigh();
      finishTxn();
   endtask

   // frame cut short by ncs
   // a frame that was kept would complete and answer in the idle bytes
   task automatic abortedFrame();
      beginTxn();
      sendByte(8'h40);
      sendByte(8'h00);
      sendByte(8'h00);
      @(negedge sclk);
      mosi = 1'b1;
      ncs = 1'b1;
      repeat (3) @(negedge sclk);
      ncs = 1'b0;
      sendIdle(6);
      finishTxn();
   endtask

   initial begin
      sclk = 1'b0;
      rstn = 1'b0;
      ncs = 1'b1;
      mosi = 1'b1;
      for (int a = 0; a < `SD_MEM_BYTES; a++)
         shadow[12'(a)] = 8'(a + 3);
      repeat (16) @(posedge sclk);
      @(negedge sclk);
      rstn = 1'b1;
      sendIdle(2);

      transact(CMD_GO_IDLE, 32'd0);
      transact(6'd5, 32'd0);                 // CMD5 is not supported
      transact(CMD_READ_BLOCK, 32'd0);       // no data follows before init
      pattern = 8'($random(seed));
      transact(CMD_SEND_IF_COND, {20'd0, 4'h1, pattern});
      pattern = 8'($random(seed));
      transact(CMD_SEND_IF_COND, {20'd0, 4'h2, pattern});   // voltage refused
      transact(CMD_APP_CMD, 32'd0);
      transact(ACMD_SEND_OP_COND, 32'h40000000);
      transact(CMD_READ_OCR, 32'd0);
      transact(CMD_READ_BLOCK, 32'd1024);
      writeBlock(12'd2048);
      transact(CMD_READ_BLOCK, 32'd2048);
      transact(CMD_READ_BLOCK, 32'd4096);    // past the end
      transact(CMD_READ_BLOCK, 32'd100);     // misaligned
      abortedFrame();
      transact(CMD_GO_IDLE, 32'd0);
      sendIdle(4);

      $display("summary: %0d checker errors, %0d timeouts", errCount, timeouts);
      if (errCount == 0 && timeouts == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: test/tbChecker.sv
// ------------------------------------------------
// SD card reply checker
// rebuilds miso bytes on rising sclk and compares
// them with the replies queued by the testbench
// ------------------------------------------------
`default_nettype none

module tbChecker (
   input  wire logic sclk,
   input  wire logic rstn,
   input  wire logic miso,
   output int        errCount
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [1:0] HUNT_ZERO  = 2'd0;   // byte starts at the first 0 on miso
   localparam logic [1:0] NEXT_BYTE  = 2'd1;   // byte follows the previous one at once
   localparam logic [1:0] HUNT_TOKEN = 2'd2;   // bit-aligned search for the value

   logic [9:0] expQ [$];        // kind and expected value
   logic [9:0] head;
   logic [7:0] shiftIn = 8'hFF;
   int         bitsIn = 0;      // bits of the current byte taken so far
   int         byteNum = 0;
   int         errors = 0;
   logic       strayShown = 1'b0;

   assign errCount = errors;

   task automatic expectFirst(input logic [7:0] value);
      expQ.push_back({HUNT_ZERO, value});
   endtask

   task automatic expectNext(input logic [7:0] value);
      expQ.push_back({NEXT_BYTE, value});
   endtask

   task automatic expectToken(input logic [7:0] value);
      expQ.push_back({HUNT_TOKEN, value});
   endtask

   function automatic int pendingBytes();
      return expQ.size();
   endfunction

   task automatic dropExpected();
      expQ.delete();
      bitsIn = 0;
   endtask

   task automatic compareByte(input logic [7:0] got);
      head = expQ.pop_front();
      byteNum++;
      if (got !== head[7:0]) begin
         $display("ERR at %0t: miso byte %0d is %02h, expected %02h",
                  $time, byteNum, got, head[7:0]);
         errors++;
      end
   endtask

   // miso moves on the falling edge, so it is steady here
   always @(posedge sclk) begin
      if (rstn) begin
         shiftIn = {shiftIn[6:0], miso};
         if (bitsIn > 0) begin
            bitsIn++;
            if (bitsIn == 8) begin
               compareByte(shiftIn);
               bitsIn = 0;
            end
         end else if (expQ.size() == 0) begin
            if (miso !== 1'b1 && !strayShown) begin
               $display("ERR at %0t: card drives miso low with no reply due", $time);
               errors++;
            end
            strayShown = (miso !== 1'b1);   // one report per low stretch
         end else begin
            head = expQ[0];
            case (head[9:8])
               NEXT_BYTE: bitsIn = 1;
               HUNT_ZERO: if (miso === 1'b0) bitsIn = 1;
               default:   if (shiftIn == head[7:0]) compareByte(shiftIn);
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/sdSpiCard.sv
// ------------------------------------------------
// SPI-mode SD card target, top level
// command capture, card state, transfer engine,
// miso output and 4 KB storage
// ------------------------------------------------
`default_nettype none

module sdSpiCard
   import sdCardPkg::*;
(
   input  wire logic sclk,
   input  wire logic rstn,
   input  wire logic ncs,
   input  wire logic mosi,
   output logic      miso
);

   logic        cmdValid;
   cmdFrameT    cmdFrame;
   logic        engineBusy;
   logic [7:0]  r1Byte;
   logic [31:0] extraWord;
   logic        hasExtra;
   dataPhaseT   phase;
   logic [11:0] blockAddr;
   logic        txLoad;
   logic [7:0]  txByte;
   logic        txDone;
   logic [11:0] memAddr;
   logic        memWe;
   logic [7:0]  memWdata;
   logic [7:0]  memRdata;

   cmdReceiver recv0 (
      .sclk, .rstn, .ncs, .mosi, .engineBusy,
      .cmdValid, .cmdFrame
   );

   cardStatus status0 (
      .sclk, .rstn, .cmdValid, .cmdFrame,
      .r1Byte, .extraWord, .hasExtra, .phase, .blockAddr
   );

   cardEngine engine0 (
      .sclk, .rstn, .ncs, .mosi, .cmdValid,
      .r1Byte, .extraWord, .hasExtra, .phase, .blockAddr,
      .txDone, .txLoad, .txByte,
      .memAddr, .memWe, .memWdata, .memRdata,
      .engineBusy
   );

   misoSerializer ser0 (
      .sclk, .rstn, .txLoad, .txByte, .txDone, .miso
   );

   blockMemory mem0 (
      .sclk, .memAddr, .memWe, .memWdata, .memRdata
   );

endmodule

`default_nettype wire

// File: hdl/blockMemory.sv
// ------------------------------------------------
// SD card storage
// byte-wide array with registered read, preloaded
// with address + 3
// ------------------------------------------------
`default_nettype none
`include "sdCard_defs.svh"

module blockMemory (
   input  wire logic        sclk,
   input  wire logic [11:0] memAddr,
   input  wire logic        memWe,
   input  wire logic [7:0]  memWdata,
   output logic [7:0]       memRdata
);

   logic [7:0] mem [`SD_MEM_BYTES];

   initial begin
      for (int i = 0; i < `SD_MEM_BYTES; i++)
         mem[i] = 8'(i + 3);   // wraps modulo 256
   end

   always_ff @(posedge sclk) begin
      if (memWe) mem[memAddr] <= memWdata;
      memRdata <= mem[memAddr];   // old data on a write cycle
   end

endmodule

`default_nettype wire

// File: hdl/misoSerializer.sv
// ------------------------------------------------
// miso byte serializer
// shifts a byte out MSB first, miso changes on
// falling sclk and idles high
// ------------------------------------------------
`default_nettype none

module misoSerializer (
   input  wire logic       sclk,
   input  wire logic       rstn,
   input  wire logic       txLoad,
   input  wire logic [7:0] txByte,
   output logic            txDone,
   output logic            miso
);

   logic [7:0] shiftReg;
   logic [2:0] bitCnt;
   logic       busy;

   assign txDone = busy && (bitCnt == 3'd7);   // last bit is on the wire

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         busy   <= 1'b0;
         bitCnt <= '0;
      end else if (txLoad) begin
         busy   <= 1'b1;
         bitCnt <= '0;
      end else if (busy) begin
         bitCnt <= bitCnt + 3'd1;
         if (bitCnt == 3'd7) busy <= 1'b0;
      end
   end

   always_ff @(posedge sclk) begin
      if (txLoad) shiftReg <= txByte;
      else if (busy) shiftReg <= {shiftReg[6:0], 1'b1};
   end

   // host samples on the rising edge, so drive half a clock ahead
   always_ff @(negedge sclk) begin
      if (!rstn) miso <= 1'b1;
      else miso <= busy ? shiftReg[7] : 1'b1;
   end

endmodule

`default_nettype wire

// File: hdl/cardEngine.sv
// ------------------------------------------------
// SD card transfer engine
// sequences NCR gap, response, read block with token
// and CRC, write block with data response and busy
// ------------------------------------------------
`default_nettype none
`include "sdCard_defs.svh"

module cardEngine
   import sdCardPkg::*;
(
   input  wire logic        sclk,
   input  wire logic        rstn,
   input  wire logic        ncs,
   input  wire logic        mosi,
   input  wire logic        cmdValid,
   input  wire logic [7:0]  r1Byte,
   input  wire logic [31:0] extraWord,
   input  wire logic        hasExtra,
   input  wire dataPhaseT   phase,
   input  wire logic [11:0] blockAddr,
   input  wire logic        txDone,
   output logic             txLoad,
   output logic [7:0]       txByte,
   output logic [11:0]      memAddr,
   output logic             memWe,
   output logic [7:0]       memWdata,
   input  wire logic [7:0]  memRdata,
   output logic             engineBusy
);

   // NCR counts from the cycle after cmdValid, NAC from the cycle after txDone
   localparam int NCR_LOAD = `SD_NCR_BYTES * 8 - 2;
   localparam int NAC_LOAD = `SD_NAC_BYTES * 8 - 1;
   localparam logic [15:0] CRC = `SD_DUMMY_CRC;

   typedef enum logic [3:0] {
      ST_IDLE, ST_NCR, ST_RESP, ST_EXTRA, ST_NAC,
      ST_RD_TOKEN, ST_RD_DATA, ST_RD_CRC,
      ST_WR_TOKEN, ST_WR_DATA, ST_WR_CRC, ST_WR_RESP, ST_WR_BUSY
   } engineStateT;

   engineStateT state;
   logic [6:0]  cnt;        // cycles in a gap, bits on mosi
   logic [9:0]  idx;        // byte index within the current phase
   logic [6:0]  rxShift;
   logic [7:0]  rxByte;
   logic [1:0]  byteSel;
   logic        respEnd;

   assign rxByte     = {rxShift, mosi};
   assign byteSel    = 2'd3 - idx[1:0];
   assign memAddr    = blockAddr + 12'(idx[8:0]);
   assign memWe      = (state == ST_WR_DATA) && (cnt == 7'd7);
   assign memWdata   = rxByte;
   assign engineBusy = (state != ST_IDLE);
   assign respEnd    = txDone && (((state == ST_RESP) && !hasExtra) ||
                                  ((state == ST_EXTRA) && (idx == 10'd4)));

   always_comb begin
      txLoad = 1'b0;
      txByte = 8'hFF;
      case (state)
         ST_NCR: begin
            txLoad = (cnt == 7'(NCR_LOAD));
            txByte = r1Byte;
         end
         ST_RESP: begin
            txLoad = txDone && hasExtra;
            txByte = extraWord[31:24];
         end
         ST_EXTRA: begin
            txLoad = txDone && (idx != 10'd4);
            txByte = extraWord[{byteSel, 3'b000} +: 8];
         end
         ST_NAC: begin
            txLoad = (cnt == 7'(NAC_LOAD));
            txByte = `SD_TOKEN_START;
         end
         ST_RD_TOKEN: begin
            txLoad = txDone;
            txByte = memRdata;
         end
         ST_RD_DATA: begin
            txLoad = txDone;
            txByte = (idx == 10'(`SD_BLOCK_LEN)) ? CRC[15:8] : memRdata;
         end
         ST_RD_CRC: begin
            txLoad = txDone && (idx == 10'd0);
            txByte = CRC[7:0];
         end
         ST_WR_CRC: begin
            txLoad = (cnt == 7'd15);   // back to back with the last CRC bit
            txByte = `SD_DATA_ACCEPTED;
         end
         ST_WR_RESP: begin
            txLoad = txDone;
            txByte = 8'h00;            // busy is just zero bytes
         end
         ST_WR_BUSY: begin
            txLoad = txDone && (idx != 10'(`SD_BUSY_BYTES - 1));
            txByte = 8'h00;
         end
         default: ;
      endcase
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         state <= ST_IDLE;
         cnt   <= '0;
         idx   <= '0;
      end else if (ncs) begin
         state <= ST_IDLE;             // host dropped the card
      end else if (respEnd) begin
         cnt <= '0;
         idx <= '0;
         case (phase)
            PHASE_READ:  state <= ST_NAC;
            PHASE_WRITE: state <= ST_WR_TOKEN;
            default:     state <= ST_IDLE;
         endcase
      end else begin
         case (state)
            ST_IDLE: if (cmdValid) begin
               state <= ST_NCR;
               cnt   <= '0;
            end
            ST_NCR: begin
               cnt <= cnt + 7'd1;
               if (txLoad) state <= ST_RESP;
            end
            ST_RESP: if (txLoad) begin
               state <= ST_EXTRA;
               idx   <= 10'd1;
            end
            ST_EXTRA:   if (txLoad) idx <= idx + 10'd1;
            ST_NAC: begin
               cnt <= cnt + 7'd1;
               if (txLoad) state <= ST_RD_TOKEN;
            end
            ST_RD_TOKEN: if (txDone) begin
               state <= ST_RD_DATA;
               idx   <= 10'd1;
            end
            ST_RD_DATA: if (txDone) begin
               if (idx == 10'(`SD_BLOCK_LEN)) begin
                  state <= ST_RD_CRC;
                  idx   <= '0;
               end else begin
                  idx <= idx + 10'd1;
               end
            end
            ST_RD_CRC: if (txDone) begin
               if (idx == 10'd0) idx <= 10'd1;
               else state <= ST_IDLE;
            end
            ST_WR_TOKEN: if (rxByte == `SD_TOKEN_START) begin   // bit aligned hunt
               state <= ST_WR_DATA;
               cnt   <= '0;
               idx   <= '0;
            end
            ST_WR_DATA: begin
               cnt <= cnt + 7'd1;
               if (cnt == 7'd7) begin
                  cnt <= '0;
                  if (idx == 10'(`SD_BLOCK_LEN - 1)) state <= ST_WR_CRC;
                  else idx <= idx + 10'd1;
               end
            end
            ST_WR_CRC: begin
               cnt <= cnt + 7'd1;
               if (txLoad) state <= ST_WR_RESP;
            end
            ST_WR_RESP: if (txDone) begin
               state <= ST_WR_BUSY;
               idx   <= '0;
            end
            ST_WR_BUSY: if (txDone) begin
               if (txLoad) idx <= idx + 10'd1;
               else state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // mosi byte assembly, cleared to ones before the token hunt
   always_ff @(posedge sclk) begin
      if (respEnd) rxShift <= 7'h7F;
      else rxShift <= rxByte[6:0];
   end

   // one byte takes 8 clocks in the serializer, so loads never overlap
   loadSpacing: assert property (@(posedge sclk) disable iff (!rstn)
      txLoad |=> !txLoad [*7]);

endmodule

`default_nettype wire

// File: hdl/cardStatus.sv
// ------------------------------------------------
// SD card state and command decode
// keeps init and app-command state, builds R1 and
// the R3/R7 tail, and picks the data phase
// ------------------------------------------------
`default_nettype none
`include "sdCard_defs.svh"

module cardStatus
   import sdCardPkg::*;
(
   input  wire logic        sclk,
   input  wire logic        rstn,
   input  wire logic        cmdValid,
   input  wire cmdFrameT    cmdFrame,
   output logic [7:0]       r1Byte,
   output logic [31:0]      extraWord,
   output logic             hasExtra,
   output dataPhaseT        phase,
   output logic [11:0]      blockAddr
);

   logic       initDone;
   logic       appCmd;      // last command was CMD55
   logic       isR7;        // tail is the CMD8 echo, else OCR
   logic [3:0] echoVhs;
   logic [7:0] echoPattern;
   logic [7:0] baseR1;
   logic       addrBad;
   logic       vhsOk;

   assign baseR1  = initDone ? 8'h00 : 8'h01;    // idle bit
   assign addrBad = (cmdFrame.arg[8:0] != 9'd0) || (cmdFrame.arg >= 32'(`SD_MEM_BYTES));
   assign vhsOk   = (cmdFrame.arg[11:8] == `SD_CARD_VHS);

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         initDone <= 1'b0;
         appCmd   <= 1'b0;
         isR7     <= 1'b0;
         hasExtra <= 1'b0;
         phase    <= PHASE_NONE;
         r1Byte   <= 8'h01;
      end else if (cmdValid) begin
         appCmd   <= 1'b0;
         isR7     <= 1'b0;
         hasExtra <= 1'b0;
         phase    <= PHASE_NONE;
         r1Byte   <= baseR1;
         case (cmdFrame.index)
            CMD_GO_IDLE: begin
               initDone <= 1'b0;
               r1Byte   <= 8'h01;
            end
            CMD_SEND_IF_COND: begin
               isR7     <= 1'b1;
               hasExtra <= 1'b1;
            end
            CMD_APP_CMD:  appCmd <= 1'b1;
            CMD_READ_OCR: hasExtra <= 1'b1;
            ACMD_SEND_OP_COND: begin
               if (appCmd) begin
                  initDone <= 1'b1;
                  r1Byte   <= 8'h00;   // init finishes at once
               end else begin
                  r1Byte <= baseR1 | 8'h04;
               end
            end
            CMD_READ_BLOCK, CMD_WRITE_BLOCK: begin
               if (!initDone)
                  r1Byte <= baseR1 | 8'h04;
               else if (addrBad)
                  r1Byte <= baseR1 | 8'h20;   // address error
               else
                  phase <= (cmdFrame.index == CMD_READ_BLOCK) ? PHASE_READ : PHASE_WRITE;
            end
            default: r1Byte <= baseR1 | 8'h04;   // illegal command
         endcase
      end
   end

   // CMD8 echo and block address
   always_ff @(posedge sclk) begin
      if (cmdValid) begin
         blockAddr <= cmdFrame.arg[11:0];
         if (cmdFrame.index == CMD_SEND_IF_COND) begin
            echoVhs     <= vhsOk ? cmdFrame.arg[11:8] : 4'h0;
            echoPattern <= cmdFrame.arg[7:0];
         end
      end
   end

   assign extraWord = isR7 ? {20'h00000, echoVhs, echoPattern}
                           : (`SD_OCR_BASE | {initDone, 31'd0});

endmodule

`default_nettype wire

// File: hdl/cmdReceiver.sv
// ------------------------------------------------
// SD command receiver
// finds the 0-1 start pattern on mosi and shifts in
// a 48-bit frame, keeping index and argument
// ------------------------------------------------
`default_nettype none

module cmdReceiver
   import sdCardPkg::*;
(
   input  wire logic sclk,
   input  wire logic rstn,
   input  wire logic ncs,
   input  wire logic mosi,
   input  wire logic engineBusy,
   output logic      cmdValid,
   output cmdFrameT  cmdFrame
);

   logic        active;      // inside a frame
   logic [5:0]  bitCnt;      // number of the bit on mosi now
   logic [37:0] frameBits;

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         active   <= 1'b0;
         bitCnt   <= '0;
         cmdValid <= 1'b0;
      end else begin
         cmdValid <= 1'b0;
         if (ncs || engineBusy) begin   // abort, frame is lost
            active <= 1'b0;
            bitCnt <= '0;
         end else if (!active) begin
            if (!mosi) begin
               active <= 1'b1;
               bitCnt <= 6'd1;
            end
         end else if (bitCnt == 6'd1) begin
            if (mosi)
               bitCnt <= 6'd2;   // transmission bit, a 0 is taken as another start bit
         end else if (bitCnt == 6'd47) begin
            active   <= 1'b0;
            bitCnt   <= '0;
            cmdValid <= mosi;    // end bit must be 1
         end else begin
            bitCnt <= bitCnt + 6'd1;
         end
      end
   end

   // bits 2..39 carry index and argument, CRC7 is not kept
   always_ff @(posedge sclk) begin
      if (active && bitCnt >= 6'd2 && bitCnt < 6'd40)
         frameBits <= {frameBits[36:0], mosi};
   end

   assign cmdFrame = cmdFrameT'(frameBits);

   // the engine holds busy from the command on, so nothing new is taken
   noCmdWhileBusy: assert property (@(posedge sclk) disable iff (!rstn)
      !(cmdValid && engineBusy));

endmodule

`default_nettype wire

// File: hdl/sdCardPkg.sv
// ------------------------------------------------
// SD card shared types
// command frame, data phase and command numbers
// ------------------------------------------------
`default_nettype none

package sdCardPkg;

   // index and argument of one captured command, CRC dropped
   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] arg;
   } cmdFrameT;

   // data transfer that follows the R1
   typedef enum logic [1:0] {
      PHASE_NONE,
      PHASE_READ,
      PHASE_WRITE
   } dataPhaseT;

   typedef enum logic [5:0] {
      CMD_GO_IDLE       = 6'd0,
      CMD_SEND_IF_COND  = 6'd8,
      CMD_READ_BLOCK    = 6'd17,
      CMD_WRITE_BLOCK   = 6'd24,
      ACMD_SEND_OP_COND = 6'd41,   // only after CMD55
      CMD_APP_CMD       = 6'd55,
      CMD_READ_OCR      = 6'd58
   } cmdIndexT;

endpackage

`default_nettype wire

// File: hdl/sdCard_defs.svh
// ------------------------------------------------
// SD card target constants
// sizes, SPI timing gaps, tokens and fixed register
// values for the SPI-mode SD card
// ------------------------------------------------
`ifndef SD_CARD_DEFS_SVH
`define SD_CARD_DEFS_SVH

// storage geometry
`define SD_MEM_BYTES      4096
`define SD_BLOCK_LEN      512

// gaps, counted in whole bytes of sclk
`define SD_NCR_BYTES      1        // command end to response
`define SD_NAC_BYTES      1        // R1 of CMD17 to start token
`define SD_BUSY_BYTES     4        // busy low after data response

// tokens and fixed values
`define SD_TOKEN_START    8'hFE
`define SD_DATA_ACCEPTED  8'h05
`define SD_DUMMY_CRC      16'hAAAA
`define SD_OCR_BASE       32'h00FF8000   // voltage window, busy bit clear
`define SD_CARD_VHS       4'h1           // 2.7 to 3.6 V

`endif
